// File: hw/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Datapath and address width
`define RV_XLEN 32

// Integer register file
`define RV_REG_COUNT 32
`define RV_REG_ADDR_W 5

`define RV_RESET_PC 32'h0000_0000 // First fetch address

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// File: hw/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_IMM    = 7'b0010011,
        OPC_REG    = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // Encoded as {inst[30], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_type_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC4,
        WB_MEM,
        WB_IMM
    } wb_sel_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // All zero is a bubble
    typedef struct packed {
        logic     rf_we;
        wb_sel_t  wb_sel;
        alu_op_t  alu_op;
        logic     src1_pc;   // ALU a is PC
        logic     src2_imm;  // ALU b is immediate
        br_type_t br_type;
        logic     jal;
        logic     jalr;
        logic     mem_we;
        logic     mem_re;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t pc4;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     pc4;
        reg_addr_t rs1;  // Zero when the source is unused
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      rf_we;
        wb_sel_t   wb_sel;
        logic      mem_we;
        logic      mem_re;
        reg_addr_t rd;
        word_t     alu_ans;  // Also the data memory address
        word_t     pc4;
        word_t     imm;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      rf_we;
        wb_sel_t   wb_sel;
        reg_addr_t rd;
        word_t     alu_ans;
        word_t     pc4;
        word_t     imm;
        word_t     mem_data;
    } mem_wb_t;

    typedef struct packed {
        logic      we;
        reg_addr_t wa;
        word_t     wd;
    } rf_write_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// File: hw/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module fetch_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_if,
    input  logic              flush_id,
    input  rv_pkg::redirect_t redirect,
    input  rv_pkg::word_t     im_dout,
    output rv_pkg::word_t     im_addr,
    output rv_pkg::if_id_t    if_id
);
    import rv_pkg::*;

    word_t pc;
    word_t pc4;

    assign pc4 = pc + word_t'(4);
    assign im_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (redirect.taken) begin
            pc <= redirect.target;  // Redirect wins over a stall
        end else if (!stall_if) begin
            pc <= pc4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_id) begin
            if_id <= '{pc: '0, pc4: '0, inst: `RV_NOP};
        end else if (!stall_if) begin
            if_id <= '{pc: pc, pc4: pc4, inst: im_dout};
        end
    end

    // Hazard unit drops the stall when a branch resolves
    assert property (@(posedge clk) disable iff (rst) !(stall_if && redirect.taken));

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_id,
    input  logic              flush_ex,
    input  rv_pkg::if_id_t    if_id,
    input  rv_pkg::rf_write_t rf_write,
    output rv_pkg::id_ex_t    id_ex,
    output logic              rs1_used,
    output logic              rs2_used,
    output logic              ebreak
);
    import rv_pkg::*;

    localparam word_t EBREAK_INST = 32'h0010_0073;

    word_t     regs [`RV_REG_COUNT];
    opcode_t   opcode;
    logic [2:0] funct3;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     inst;
    word_t     imm;
    ctrl_t     ctrl;

    assign inst = if_id.inst;
    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];

    assign rs1_used = opcode inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_IMM, OPC_REG};
    assign rs2_used = opcode inside {OPC_BRANCH, OPC_STORE, OPC_REG};
    assign rs1 = rs1_used ? inst[19:15] : '0;
    assign rs2 = rs2_used ? inst[24:20] : '0;

    // A shadowed EBREAK is about to be flushed
    assign ebreak = (inst == EBREAK_INST) && !flush_ex;

    always_comb begin
        ctrl = '0;
        imm = '0;
        case (opcode)
            OPC_LUI: begin
                ctrl.rf_we = 1'b1;
                ctrl.wb_sel = WB_IMM;
                imm = {inst[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                ctrl.rf_we = 1'b1;
                ctrl.src1_pc = 1'b1;
                ctrl.src2_imm = 1'b1;
                imm = {inst[31:12], 12'b0};
            end
            OPC_JAL: begin
                ctrl.rf_we = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.src1_pc = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.jal = 1'b1;
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl.rf_we = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.src2_imm = 1'b1;
                ctrl.jalr = 1'b1;
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            OPC_BRANCH: begin
                ctrl.src1_pc = 1'b1;   // ALU forms the target
                ctrl.src2_imm = 1'b1;
                case (funct3)
                    3'b000: ctrl.br_type = BR_EQ;
                    3'b001: ctrl.br_type = BR_NE;
                    3'b100: ctrl.br_type = BR_LT;
                    3'b101: ctrl.br_type = BR_GE;
                    3'b110: ctrl.br_type = BR_LTU;
                    3'b111: ctrl.br_type = BR_GEU;
                    default: ctrl.br_type = BR_NONE;
                endcase
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_LOAD: begin
                ctrl.rf_we = 1'b1;
                ctrl.wb_sel = WB_MEM;
                ctrl.src2_imm = 1'b1;
                ctrl.mem_re = 1'b1;
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            OPC_STORE: begin
                ctrl.src2_imm = 1'b1;
                ctrl.mem_we = 1'b1;
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OPC_IMM: begin
                ctrl.rf_we = 1'b1;
                ctrl.src2_imm = 1'b1;
                // inst[30] only selects SRAI here
                ctrl.alu_op = alu_op_t'({funct3 == 3'b101 && inst[30], funct3});
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            OPC_REG: begin
                ctrl.rf_we = 1'b1;
                ctrl.alu_op = alu_op_t'({inst[30], funct3});
            end
            default: ;  // EBREAK and unknown ops do nothing
        endcase
    end

    always_ff @(posedge clk) begin
        if (rf_write.we && rf_write.wa != '0) begin
            regs[rf_write.wa] <= rf_write.wd;
        end
    end

    // Same-cycle writeback passes straight through
    assign rs1_val = (rs1 == '0) ? '0 :
                     (rf_write.we && rf_write.wa == rs1) ? rf_write.wd : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (rf_write.we && rf_write.wa == rs2) ? rf_write.wd : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst || flush_ex || stall_id) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl <= ctrl;
            id_ex.pc <= if_id.pc;
            id_ex.pc4 <= if_id.pc4;
            id_ex.rs1 <= rs1;
            id_ex.rs2 <= rs2;
            id_ex.rd <= inst[11:7];
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
            id_ex.imm <= imm;
        end
    end

    // IF/ID holds while ID stalls
    assert property (@(posedge clk) disable iff (rst) stall_id |=> $stable(if_id));

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::fwd_sel_t  fwd_rs1,
    input  rv_pkg::fwd_sel_t  fwd_rs2,
    input  rv_pkg::rf_write_t rf_write,
    output rv_pkg::redirect_t redirect,
    output rv_pkg::ex_mem_t   ex_mem
);
    import rv_pkg::*;

    word_t mem_fwd;
    word_t rs1_val;
    word_t rs2_val;
    word_t src1;
    word_t src2;
    word_t alu_ans;
    logic  br_taken;

    function automatic word_t pick_operand(fwd_sel_t sel, word_t id_val, word_t mem_val,
                                           word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return id_val;
        endcase
    endfunction

    // Loads never forward from MEM
    always_comb begin
        case (ex_mem.wb_sel)
            WB_PC4:  mem_fwd = ex_mem.pc4;
            WB_IMM:  mem_fwd = ex_mem.imm;
            default: mem_fwd = ex_mem.alu_ans;
        endcase
    end

    assign rs1_val = pick_operand(fwd_rs1, id_ex.rs1_val, mem_fwd, rf_write.wd);
    assign rs2_val = pick_operand(fwd_rs2, id_ex.rs2_val, mem_fwd, rf_write.wd);
    assign src1 = id_ex.ctrl.src1_pc ? id_ex.pc : rs1_val;
    assign src2 = id_ex.ctrl.src2_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:  alu_ans = src1 + src2;
            ALU_SUB:  alu_ans = src1 - src2;
            ALU_SLL:  alu_ans = src1 << src2[4:0];
            ALU_SLT:  alu_ans = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU: alu_ans = word_t'(src1 < src2);
            ALU_XOR:  alu_ans = src1 ^ src2;
            ALU_SRL:  alu_ans = src1 >> src2[4:0];
            ALU_SRA:  alu_ans = word_t'($signed(src1) >>> src2[4:0]);
            ALU_OR:   alu_ans = src1 | src2;
            ALU_AND:  alu_ans = src1 & src2;
            default:  alu_ans = '0;
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.br_type)
            BR_EQ:   br_taken = rs1_val == rs2_val;
            BR_NE:   br_taken = rs1_val != rs2_val;
            BR_LT:   br_taken = $signed(rs1_val) < $signed(rs2_val);
            BR_GE:   br_taken = $signed(rs1_val) >= $signed(rs2_val);
            BR_LTU:  br_taken = rs1_val < rs2_val;
            BR_GEU:  br_taken = rs1_val >= rs2_val;
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect.taken = id_ex.ctrl.jal || id_ex.ctrl.jalr || br_taken;
    assign redirect.target = id_ex.ctrl.jalr ? {alu_ans[`RV_XLEN-1:1], 1'b0} : alu_ans;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.rf_we <= id_ex.ctrl.rf_we;
            ex_mem.wb_sel <= id_ex.ctrl.wb_sel;
            ex_mem.mem_we <= id_ex.ctrl.mem_we;
            ex_mem.mem_re <= id_ex.ctrl.mem_re;
            ex_mem.rd <= id_ex.rd;
            ex_mem.alu_ans <= alu_ans;
            ex_mem.pc4 <= id_ex.pc4;
            ex_mem.imm <= id_ex.imm;
            ex_mem.store_data <= rs2_val;
        end
    end

    // Slot behind a jump becomes a bubble
    assert property (@(posedge clk) disable iff (rst)
        (id_ex.ctrl.jal || id_ex.ctrl.jalr) |=> (id_ex.ctrl == '0));

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::if_id_t    if_id,
    input  logic              rs1_used,
    input  logic              rs2_used,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::rf_write_t rf_write,
    input  rv_pkg::redirect_t redirect,
    input  logic              ebreak,
    output logic              stall_if,
    output logic              stall_id,
    output logic              flush_id,
    output logic              flush_ex,
    output rv_pkg::fwd_sel_t  fwd_rs1,
    output rv_pkg::fwd_sel_t  fwd_rs2
);
    import rv_pkg::*;

    logic load_use;

    // MEM before WB, x0 never
    function automatic fwd_sel_t fwd_pick(reg_addr_t rs, ex_mem_t mem, rf_write_t wb);
        if (rs == '0) begin
            return FWD_NONE;
        end
        if (mem.rf_we && !mem.mem_re && mem.rd == rs) begin
            return FWD_MEM;
        end
        if (wb.we && wb.wa == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign load_use = id_ex.ctrl.mem_re && id_ex.rd != '0 &&
                      ((rs1_used && if_id.inst[19:15] == id_ex.rd) ||
                       (rs2_used && if_id.inst[24:20] == id_ex.rd));

    assign stall_if = (load_use || ebreak) && !redirect.taken;
    assign stall_id = stall_if;
    assign flush_id = redirect.taken;
    assign flush_ex = redirect.taken;

    assign fwd_rs1 = fwd_pick(id_ex.rs1, ex_mem, rf_write);
    assign fwd_rs2 = fwd_pick(id_ex.rs2, ex_mem, rf_write);

    // Flushed slot cannot redirect again
    assert property (@(posedge clk) disable iff (rst)
        redirect.taken |=> !redirect.taken);

endmodule

// File: hw/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::word_t     mem_dout,
    output rv_pkg::rf_write_t rf_write
);
    import rv_pkg::*;

    mem_wb_t mem_wb;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.rf_we <= ex_mem.rf_we;
            mem_wb.wb_sel <= ex_mem.wb_sel;
            mem_wb.rd <= ex_mem.rd;
            mem_wb.alu_ans <= ex_mem.alu_ans;
            mem_wb.pc4 <= ex_mem.pc4;
            mem_wb.imm <= ex_mem.imm;
            mem_wb.mem_data <= mem_dout;  // Combinational read at alu_ans
        end
    end

    always_comb begin
        rf_write.we = mem_wb.rf_we;
        rf_write.wa = mem_wb.rd;
        case (mem_wb.wb_sel)
            WB_PC4:  rf_write.wd = mem_wb.pc4;
            WB_MEM:  rf_write.wd = mem_wb.mem_data;
            WB_IMM:  rf_write.wd = mem_wb.imm;
            default: rf_write.wd = mem_wb.alu_ans;
        endcase
    end

endmodule

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic          clk,
    input  logic          rst,
    output rv_pkg::word_t im_addr,
    input  rv_pkg::word_t im_dout,
    output rv_pkg::word_t mem_addr,
    output logic          mem_we,
    output rv_pkg::word_t mem_din,
    input  rv_pkg::word_t mem_dout,
    output logic          ebreak
);
    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    rf_write_t rf_write;
    redirect_t redirect;
    fwd_sel_t  fwd_rs1;
    fwd_sel_t  fwd_rs2;
    logic      stall_if;
    logic      stall_id;
    logic      flush_id;
    logic      flush_ex;
    logic      rs1_used;
    logic      rs2_used;

    // Data memory port straight off EX/MEM
    assign mem_addr = ex_mem.alu_ans;
    assign mem_we = ex_mem.mem_we;
    assign mem_din = ex_mem.store_data;

    fetch_stage fetch_stage0 (
        .clk(clk), .rst(rst), .stall_if(stall_if), .flush_id(flush_id),
        .redirect(redirect), .im_dout(im_dout), .im_addr(im_addr), .if_id(if_id)
    );

    decode_stage decode_stage0 (
        .clk(clk), .rst(rst), .stall_id(stall_id), .flush_ex(flush_ex),
        .if_id(if_id), .rf_write(rf_write), .id_ex(id_ex),
        .rs1_used(rs1_used), .rs2_used(rs2_used), .ebreak(ebreak)
    );

    execute_stage execute_stage0 (
        .clk(clk), .rst(rst), .id_ex(id_ex), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
        .rf_write(rf_write), .redirect(redirect), .ex_mem(ex_mem)
    );

    writeback_stage writeback_stage0 (
        .clk(clk), .rst(rst), .ex_mem(ex_mem), .mem_dout(mem_dout), .rf_write(rf_write)
    );

    hazard_unit hazard_unit0 (
        .clk(clk), .rst(rst), .if_id(if_id), .rs1_used(rs1_used), .rs2_used(rs2_used),
        .id_ex(id_ex), .ex_mem(ex_mem), .rf_write(rf_write), .redirect(redirect),
        .ebreak(ebreak), .stall_if(stall_if), .stall_id(stall_id),
        .flush_id(flush_id), .flush_ex(flush_ex), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2)
    );

endmodule

// File: test/tb_cpu.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_cpu;
    import rv_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 4;  // Older instructions behind EBREAK
    localparam word_t POISON_ADDR = 32'h0000_00fc;
    localparam word_t EBREAK_INST = 32'h0010_0073;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    logic  clk;
    logic  rst;
    word_t im_addr;
    word_t im_dout;
    word_t mem_addr;
    logic  mem_we;
    word_t mem_din;
    word_t mem_dout;
    logic  ebreak;

    word_t imem [64];
    word_t dmem [64];
    word_t exp_addr [16];
    word_t exp_data [16];
    int    exp_count = 0;
    int    prog_len = 0;
    int    store_idx = 0;
    int    cycle = 0;
    int    err_count = 0;
    int    test_errs_base = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    cpu dut0 (
        .clk(clk), .rst(rst), .im_addr(im_addr), .im_dout(im_dout),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_din(mem_din),
        .mem_dout(mem_dout), .ebreak(ebreak)
    );

    // Both memories read combinationally
    assign im_dout = imem[im_addr[7:2]];
    assign mem_dout = dmem[mem_addr[7:2]];

    function automatic word_t fill_word(int idx);
        logic [15:0] byte_addr;
        byte_addr = 16'(idx * 4);
        return {byte_addr ^ 16'hd00d, byte_addr + 16'h0100};
    endfunction

    function automatic word_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                     logic [6:0] opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, int rs2, int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [12:0] off, int rs2, int rs1, logic [2:0] f3);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, int rd, logic [6:0] opc);
        return {imm, 5'(rd), opc};
    endfunction

    function automatic word_t j_type(logic [20:0] off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic emit(word_t inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    // Must never reach the write port
    task automatic shadow_store();
        emit(s_type(POISON_ADDR[11:0], 0, 0));
    endtask

    task automatic expect_store(word_t addr, word_t data);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    // Taken skips a shadow store, fall-through bumps x14
    task automatic branch_pair(logic [2:0] f3, int rs1, int rs2, logic taken,
                               inout int not_taken);
        emit(b_type(13'd8, rs2, rs1, f3));
        if (taken) begin
            shadow_store();
        end else begin
            emit(i_type(12'd1, 14, 3'b000, 14, OP_IMM));
            not_taken++;
        end
    endtask

    task automatic report_value(string name, word_t expected, word_t actual);
        $display("ERR %s expected 0x%08h got 0x%08h at cycle %0d", name, expected, actual, cycle);
        err_count++;
    endtask

    task automatic report_failure(string what);
        $display("Cycle %0d: %s", cycle, what);
        err_count++;
    endtask

    task automatic finish_test(string name);
        int errs;
        errs = err_count - test_errs_base;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-12s %s, %0d errors", name, (errs == 0) ? "pass" : "fail", errs);
        test_errs_base = err_count;
    endtask

    task automatic wait_for_stores(int n);
        while (store_idx < n) @(posedge clk);
        @(posedge clk);  // Checks of the last store have run
    endtask

    task automatic load_program();
        word_t x1, x2, x3, x4, x5, x6, x7, x8, x9, x13;
        word_t link_pc;
        int    not_taken;
        not_taken = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = `RV_NOP;
            dmem[i] <= fill_word(i);
        end
        // Dependent chain, no spacing
        x1 = {20'h12345, 12'h000};
        emit(u_type(20'h12345, 1, OP_LUI));
        x2 = x1 + 32'h678;
        emit(i_type(12'h678, 1, 3'b000, 2, OP_IMM));
        emit(s_type(12'h080, 2, 0));
        expect_store(32'h80, x2);
        x3 = word_t'(prog_len * 4) + {20'h00001, 12'h000};  // AUIPC adds its own PC
        emit(u_type(20'h00001, 3, OP_AUIPC));
        x4 = x3 + x2;
        emit(r_type(7'b0000000, 2, 3, 3'b000, 4));
        x5 = x4 - x1;
        emit(r_type(7'b0100000, 1, 4, 3'b000, 5));
        x6 = x5 ^ 32'hffff_ffff;
        emit(i_type(12'hfff, 5, 3'b100, 6, OP_IMM));
        x7 = word_t'($signed(x6) >>> 4);
        emit(i_type(12'h404, 6, 3'b101, 7, OP_IMM));  // SRAI
        emit(s_type(12'h084, 7, 0));
        expect_store(32'h84, x7);
        x8 = (x5 < x7) ? 32'd1 : 32'd0;
        emit(r_type(7'b0000000, 7, 5, 3'b011, 8));
        x9 = x5 << x8[4:0];
        emit(r_type(7'b0000000, 8, 5, 3'b001, 9));
        emit(i_type(12'h088, 0, 3'b000, 11, OP_IMM));
        emit(s_type(12'h000, 9, 11));  // Base from MEM, data from WB
        expect_store(32'h88, x9);
        // Load then immediate use
        emit(i_type(12'h020, 0, 3'b010, 12, OP_LOAD));
        x13 = fill_word(8) + x5;
        emit(r_type(7'b0000000, 5, 12, 3'b000, 13));
        emit(s_type(12'h08c, 13, 0));
        expect_store(32'h8c, x13);
        // x5 positive, x7 negative
        emit(i_type(12'h000, 0, 3'b000, 14, OP_IMM));
        branch_pair(3'b000, 5, 5, 1'b1, not_taken);  // BEQ
        branch_pair(3'b000, 5, 7, 1'b0, not_taken);
        branch_pair(3'b001, 5, 7, 1'b1, not_taken);  // BNE
        branch_pair(3'b001, 5, 5, 1'b0, not_taken);
        branch_pair(3'b100, 7, 5, 1'b1, not_taken);  // BLT
        branch_pair(3'b100, 5, 7, 1'b0, not_taken);
        branch_pair(3'b101, 5, 7, 1'b1, not_taken);  // BGE
        branch_pair(3'b101, 7, 5, 1'b0, not_taken);
        branch_pair(3'b110, 5, 7, 1'b1, not_taken);  // BLTU
        branch_pair(3'b110, 7, 5, 1'b0, not_taken);
        branch_pair(3'b111, 7, 5, 1'b1, not_taken);  // BGEU
        branch_pair(3'b111, 5, 7, 1'b0, not_taken);
        emit(s_type(12'h090, 14, 0));
        expect_store(32'h90, word_t'(not_taken));
        link_pc = word_t'(prog_len * 4);
        emit(j_type(21'd8, 15));
        shadow_store();
        emit(s_type(12'h094, 15, 0));
        expect_store(32'h94, link_pc + 4);
        // Odd base, JALR clears bit 0 and lands past its shadow
        emit(i_type(12'(prog_len * 4 + 13), 0, 3'b000, 16, OP_IMM));
        link_pc = word_t'(prog_len * 4);
        emit(i_type(12'h000, 16, 3'b000, 17, OP_JALR));
        shadow_store();
        emit(s_type(12'h098, 17, 0));
        expect_store(32'h98, link_pc + 4);
        emit(EBREAK_INST);
        shadow_store();
        shadow_store();
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (mem_we) begin
            dmem[mem_addr[7:2]] <= mem_din;
        end
        if (!rst && mem_we) begin
            store_idx <= store_idx + 1;
        end
    end

    assert property (@(posedge clk) (rst && cycle > 0) |-> (!mem_we && !ebreak))
        else report_failure("mem_we or ebreak went high during reset");
    assert property (@(posedge clk) $fell(rst) |-> (!mem_we && !ebreak))
        else report_failure("mem_we or ebreak high on the first cycle after reset");
    assert property (@(posedge clk) $fell(rst) |-> (im_addr == `RV_RESET_PC))
        else report_value("im_addr", `RV_RESET_PC, $sampled(im_addr));
    assert property (@(posedge clk) disable iff (rst) mem_we |-> (mem_addr != POISON_ADDR))
        else report_failure("a store from a flushed or halted slot reached the data memory");
    assert property (@(posedge clk) disable iff (rst) mem_we |-> (store_idx < exp_count))
        else report_failure("more stores reached the data memory than the program makes");
    assert property (@(posedge clk) disable iff (rst)
        (mem_we && store_idx < exp_count) |-> (mem_addr == exp_addr[store_idx]))
        else report_value("mem_addr", exp_addr[$sampled(store_idx)], $sampled(mem_addr));
    assert property (@(posedge clk) disable iff (rst)
        (mem_we && store_idx < exp_count) |-> (mem_din == exp_data[store_idx]))
        else report_value("mem_din", exp_data[$sampled(store_idx)], $sampled(mem_din));
    assert property (@(posedge clk) disable iff (rst) ebreak |=> ebreak)
        else report_failure("ebreak dropped after the halt");

    initial begin
        rst <= 1'b1;
        load_program();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        finish_test("reset");
        wait_for_stores(3);
        finish_test("forwarding");
        wait_for_stores(4);
        finish_test("load-use");
        while (!ebreak) @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);
        finish_test("control");
        repeat (DRAIN_CYCLES) @(posedge clk);  // Halt holds and nothing more is stored
        if (store_idx != exp_count) begin
            report_failure($sformatf("only %0d of %0d expected stores were seen",
                                     store_idx, exp_count));
        end
        finish_test("halt");
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Program length is known before the first edge
    initial begin
        while (cycle < RESET_CYCLES + 12 * prog_len) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d stores seen",
                 cycle, store_idx, exp_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: src.f
+incdir+hw
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/hazard_unit.sv
hw/writeback_stage.sv
hw/cpu.sv
test/tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build the CPU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_cpu \
    -Mdir obj_dir -o tb_cpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_cpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
